// File: filelist.f
hw/exec_pkg.sv
hw/issue_if.sv
hw/pipe_delay.sv
hw/int_alu.sv
hw/exec_unit.sv
hw/register_file.sv
hw/exec_top.sv
dv/clock_gen.sv
dv/exec_asserts.sv
dv/exec_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the exec stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f --top-module exec_tb -o exec_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/exec_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qF "*** TEST PASSED ***" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// File: dv/exec_tb.sv
`timescale 1ns/1ps

module exec_tb;

    localparam int PERIOD       = 20;
    localparam int RESET_CYCLES = 8;
    // Result and writeback both land ALU_DEPTH edges after the issue edge
    localparam int LATENCY      = exec_pkg::ALU_DEPTH;
    localparam int N_RANDOM     = 150;
    localparam int N_DIRECTED   = 60;
    localparam int N_HOST       = 80;
    localparam int MARGIN       = 100;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + N_RANDOM + N_DIRECTED + N_HOST + MARGIN;

    logic                clock;
    logic                rst_n;
    logic                issue_valid;
    exec_pkg::opcode_e   issue_opcode;
    exec_pkg::reg_addr_t issue_src_a;
    exec_pkg::reg_addr_t issue_src_b;
    exec_pkg::reg_addr_t issue_dest;
    exec_pkg::word_t     issue_immediate;
    logic                host_wr_valid;
    exec_pkg::reg_addr_t host_wr_addr;
    exec_pkg::word_t     host_wr_data;
    exec_pkg::reg_addr_t host_rd_addr;
    exec_pkg::word_t     host_rd_data;
    logic                result_valid;
    exec_pkg::word_t     result_data;
    exec_pkg::reg_addr_t result_dest;

    exec_pkg::word_t     reg_model [16];
    int                  due_q [$];
    exec_pkg::reg_addr_t dest_q [$];
    exec_pkg::word_t     data_q [$];
    logic                exp_valid;
    exec_pkg::reg_addr_t exp_dest;
    exec_pkg::word_t     exp_data;
    int                  edge_cnt;
    int                  value_errs;
    int                  other_errs;
    int                  seed;

    exec_pkg::opcode_e arith_ops [12] = '{exec_pkg::ADD, exec_pkg::SUB, exec_pkg::MUL,
        exec_pkg::LAND, exec_pkg::LOR, exec_pkg::LXOR, exec_pkg::LNOT, exec_pkg::SATP,
        exec_pkg::SATN, exec_pkg::ABS, exec_pkg::POPCNT, exec_pkg::LDC};

    clock_gen #(.PERIOD(PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clock (
        .clock (clock),
        .rst_n (rst_n)
    );

    exec_top i_dut (.*);

    // Bit 32 says whether the op writes a result, the low word is the value
    function automatic logic [32:0] ref_result(input exec_pkg::opcode_e op,
                                               input logic [31:0] a, input logic [31:0] b,
                                               input logic [31:0] imm);
        logic signed [63:0] prod;
        int                 ones;
        prod = $signed(a) * $signed(b);
        ones = 0;
        for (int i = 0; i < 32; i++) begin
            ones += a[i];
        end
        case (op)
            exec_pkg::ADD:    return {1'b1, a + b};
            exec_pkg::SUB:    return {1'b1, a - b};
            exec_pkg::MUL:    return {1'b1, prod[31:0]};
            exec_pkg::LAND:   return {1'b1, a & b};
            exec_pkg::LOR:    return {1'b1, a | b};
            exec_pkg::LXOR:   return {1'b1, a ^ b};
            exec_pkg::LNOT:   return {1'b1, ~a};
            exec_pkg::SATP:   return {1'b1, ($signed(a) < $signed(b)) ? a : b};
            exec_pkg::SATN:   return {1'b1, ($signed(a) > $signed(b)) ? a : b};
            exec_pkg::ABS:    return {1'b1, a[31] ? -a : a};
            exec_pkg::POPCNT: return {1'b1, 32'(ones)};
            exec_pkg::LDC:    return {1'b1, imm};
            exec_pkg::BGT:    return {1'b1, {32{$signed(a) > $signed(b)}}};
            exec_pkg::BLE:    return {1'b1, {32{$signed(a) <= $signed(b)}}};
            exec_pkg::BEQ:    return {1'b1, {32{a == b}}};
            exec_pkg::BNE:    return {1'b1, {32{a != b}}};
            default:          return 33'd0;
        endcase
    endfunction

    task automatic compare_outputs();
        assert (result_valid === exp_valid) else begin
            value_errs++;
            $display("ERR t=%0t result_valid exp=%0b got=%0b", $time, exp_valid, result_valid);
        end
        if (exp_valid) begin
            assert (result_data === exp_data) else begin
                value_errs++;
                $display("ERR t=%0t result_data exp=%h got=%h", $time, exp_data, result_data);
            end
            assert (result_dest === exp_dest) else begin
                value_errs++;
                $display("ERR t=%0t result_dest exp=%0d got=%0d", $time, exp_dest, result_dest);
            end
        end
    endtask

    // Register model and comparison, both on the edge where the DUT samples
    always @(posedge clock) begin
        logic [32:0] r;
        if (!rst_n) begin
            exp_valid = 1'b0;
            compare_outputs();
            for (int i = 0; i < 16; i++) begin
                reg_model[i] = '0;
            end
        end else begin
            edge_cnt++;
            compare_outputs();
            if (issue_valid) begin
                r = ref_result(issue_opcode, reg_model[issue_src_a], reg_model[issue_src_b],
                               issue_immediate);
                if (r[32]) begin
                    due_q.push_back(edge_cnt + LATENCY);
                    dest_q.push_back(issue_dest);
                    data_q.push_back(r[31:0]);
                end
            end
            if (host_wr_valid) begin
                reg_model[host_wr_addr] = host_wr_data;
            end
            // The writeback lands after the host write, so it wins a collision
            exp_valid = 1'b0;
            if (due_q.size() != 0 && due_q[0] == edge_cnt) begin
                void'(due_q.pop_front());
                exp_dest = dest_q.pop_front();
                exp_data = data_q.pop_front();
                exp_valid = 1'b1;
                reg_model[exp_dest] = exp_data;
            end
        end
    end

    task automatic drive_issue(input exec_pkg::opcode_e op, input exec_pkg::reg_addr_t sa,
                               input exec_pkg::reg_addr_t sb, input exec_pkg::reg_addr_t d,
                               input exec_pkg::word_t imm);
        @(negedge clock);
        host_wr_valid   = 1'b0;
        issue_valid     = 1'b1;
        issue_opcode    = op;
        issue_src_a     = sa;
        issue_src_b     = sb;
        issue_dest      = d;
        issue_immediate = imm;
    endtask

    task automatic drive_idle();
        @(negedge clock);
        issue_valid   = 1'b0;
        host_wr_valid = 1'b0;
    endtask

    task automatic host_write(input exec_pkg::reg_addr_t addr, input exec_pkg::word_t data);
        @(negedge clock);
        issue_valid   = 1'b0;
        host_wr_valid = 1'b1;
        host_wr_addr  = addr;
        host_wr_data  = data;
    endtask

    task automatic check_readback(input exec_pkg::reg_addr_t addr, input exec_pkg::word_t exp);
        @(negedge clock);
        issue_valid   = 1'b0;
        host_wr_valid = 1'b0;
        host_rd_addr  = addr;
        #1;
        assert (host_rd_data === exp) else begin
            value_errs++;
            $display("ERR t=%0t host_rd_data[%0d] exp=%h got=%h", $time, addr, exp, host_rd_data);
        end
    endtask

    initial begin
        issue_valid = 1'b0;
        issue_opcode = exec_pkg::NOP;
        issue_src_a = '0;
        issue_src_b = '0;
        issue_dest = '0;
        issue_immediate = '0;
        host_wr_valid = 1'b0;
        host_wr_addr = '0;
        host_wr_data = '0;
        host_rd_addr = '0;
        edge_cnt = 0;
        value_errs = 0;
        other_errs = 0;
        seed = 32'h9bcd_d9e7;
        @(posedge rst_n);
        for (int i = 0; i < 16; i++) begin
            check_readback(exec_pkg::reg_addr_t'(i), '0);
        end
        // Random contents in r0..r12, corner values kept in r13..r15
        for (int i = 0; i < 13; i++) begin
            host_write(exec_pkg::reg_addr_t'(i), $random(seed));
        end
        host_write(13, 32'h8000_0000);
        host_write(14, 32'hffff_ffff);
        host_write(15, 32'h0000_0000);
        for (int i = 0; i < 16; i++) begin
            check_readback(exec_pkg::reg_addr_t'(i), reg_model[i]);
        end
        for (int i = 0; i < N_RANDOM; i++) begin
            drive_issue(arith_ops[$unsigned($random(seed)) % 12],
                        exec_pkg::reg_addr_t'($random(seed)),
                        exec_pkg::reg_addr_t'($random(seed)),
                        exec_pkg::reg_addr_t'($unsigned($random(seed)) % 13),
                        $random(seed));
        end
        // Let the random ops retire so their writebacks cannot replace the compare operands
        while (due_q.size() != 0) begin
            drive_idle();
        end
        host_write(1, 32'd5);
        host_write(2, 32'd5);
        host_write(3, 32'hffff_fffd);
        host_write(4, 32'd7);
        for (int op = exec_pkg::BGT; op <= exec_pkg::BNE; op++) begin
            drive_issue(exec_pkg::opcode_e'(op), 1, 2, 10, '0);
            drive_issue(exec_pkg::opcode_e'(op), 4, 3, 11, '0);
            drive_issue(exec_pkg::opcode_e'(op), 3, 4, 12, '0);
        end
        drive_issue(exec_pkg::NOP, 1, 2, 5, '0);
        drive_idle();
        drive_issue(exec_pkg::opcode_e'(5'd20), 1, 2, 6, '0);
        drive_issue(exec_pkg::opcode_e'(5'd31), 1, 2, 7, '0);
        repeat (3) drive_idle();
        // Dependent reads 4 and 5 cycles after the producer, only the second sees its value
        host_write(1, 32'h0000_1111);
        drive_issue(exec_pkg::LDC, 0, 0, 1, 32'h0000_2222);
        repeat (LATENCY - 1) drive_idle();
        drive_issue(exec_pkg::ADD, 1, 15, 2, '0);
        drive_issue(exec_pkg::ADD, 1, 15, 3, '0);
        repeat (LATENCY + 1) drive_idle();
        check_readback(2, 32'h0000_1111);
        check_readback(3, 32'h0000_2222);
        // Host write to r5 on the same edge as the LDC writeback to r5
        drive_issue(exec_pkg::LDC, 0, 0, 5, 32'h5a5a_0f0f);
        repeat (LATENCY - 1) drive_idle();
        host_write(5, 32'hdead_0000);
        drive_idle();
        check_readback(5, 32'h5a5a_0f0f);
        while (due_q.size() != 0) begin
            drive_idle();
        end
        repeat (2) drive_idle();
        for (int i = 0; i < 16; i++) begin
            check_readback(exec_pkg::reg_addr_t'(i), reg_model[i]);
        end
        $display("Errors: value=%0d other=%0d", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * PERIOD);
        other_errs++;
        $display("Watchdog expired before the test sequence completed");
        $display("Errors: value=%0d other=%0d", value_errs, other_errs);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: dv/exec_asserts.sv
`timescale 1ns/1ps

module exec_asserts (
    input logic              clock,
    input logic              rst_n,
    input exec_pkg::opcode_e op_in,
    input exec_pkg::opcode_e op_dly,
    input logic              result_valid,
    input exec_pkg::word_t   result_data
);

    logic seen_issue;
    logic no_result_op;
    logic compare_op;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            seen_issue <= 1'b0;
        end else if (op_in != exec_pkg::NOP) begin
            seen_issue <= 1'b1;
        end
    end

    // Codes above BNE are undefined and behave like NOP
    assign no_result_op = (op_dly == exec_pkg::NOP) || (op_dly > exec_pkg::BNE);
    assign compare_op   = (op_dly >= exec_pkg::BGT) && (op_dly <= exec_pkg::BNE);

    quiet_until_issue: assert property (@(posedge clock) disable iff (!rst_n)
        !seen_issue |-> !result_valid)
        else $error("result_valid raised before any issue");

    no_result_is_quiet: assert property (@(posedge clock) disable iff (!rst_n)
        no_result_op |=> !result_valid)
        else $error("result_valid raised for an op without a result");

    compare_is_mask: assert property (@(posedge clock) disable iff (!rst_n)
        compare_op |=> (result_data == '0 || result_data == '1))
        else $error("compare result is neither all ones nor zero");

endmodule

bind exec_unit exec_asserts i_asserts (
    .clock        (clock),
    .rst_n        (rst_n),
    .op_in        (op_in),
    .op_dly       (op_dly),
    .result_valid (result_valid),
    .result_data  (result_data)
);

// File: dv/clock_gen.sv
`timescale 1ns/1ps

// Free-running clock and an active-low reset held for a fixed number of cycles
module clock_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 8
) (
    output logic clock,
    output logic rst_n
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    // Release on a falling edge so the first sampled edge sees a clean reset level
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
    end

endmodule

// File: hw/exec_top.sv
`timescale 1ns/1ps

module exec_top (
    input  logic                clock,
    input  logic                rst_n,
    input  logic                issue_valid,
    input  exec_pkg::opcode_e   issue_opcode,
    input  exec_pkg::reg_addr_t issue_src_a,
    input  exec_pkg::reg_addr_t issue_src_b,
    input  exec_pkg::reg_addr_t issue_dest,
    input  exec_pkg::word_t     issue_immediate,
    input  logic                host_wr_valid,
    input  exec_pkg::reg_addr_t host_wr_addr,
    input  exec_pkg::word_t     host_wr_data,
    input  exec_pkg::reg_addr_t host_rd_addr,
    output exec_pkg::word_t     host_rd_data,
    output logic                result_valid,
    output exec_pkg::word_t     result_data,
    output exec_pkg::reg_addr_t result_dest
);

    issue_if issue ();

    logic                wb_valid;
    exec_pkg::reg_addr_t wb_dest;
    exec_pkg::word_t     wb_data;

    assign issue.valid     = issue_valid;
    assign issue.opcode    = issue_opcode;
    assign issue.immediate = issue_immediate;
    assign issue.dest      = issue_dest;

    // Operands come straight from the read ports in the issue cycle
    register_file u_regs (
        .clock         (clock),
        .rst_n         (rst_n),
        .rd_addr_a     (issue_src_a),
        .rd_addr_b     (issue_src_b),
        .rd_data_a     (issue.operand_a),
        .rd_data_b     (issue.operand_b),
        .wb_valid      (wb_valid),
        .wb_dest       (wb_dest),
        .wb_data       (wb_data),
        .host_wr_valid (host_wr_valid),
        .host_wr_addr  (host_wr_addr),
        .host_wr_data  (host_wr_data),
        .host_rd_addr  (host_rd_addr),
        .host_rd_data  (host_rd_data)
    );

    exec_unit u_exec (
        .clock        (clock),
        .rst_n        (rst_n),
        .issue        (issue),
        .result_valid (result_valid),
        .result_data  (result_data),
        .result_dest  (result_dest),
        .wb_valid     (wb_valid),
        .wb_dest      (wb_dest),
        .wb_data      (wb_data)
    );

endmodule

// File: hw/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic                clock,
    input  logic                rst_n,
    input  exec_pkg::reg_addr_t rd_addr_a,
    input  exec_pkg::reg_addr_t rd_addr_b,
    output exec_pkg::word_t     rd_data_a,
    output exec_pkg::word_t     rd_data_b,
    input  logic                wb_valid,
    input  exec_pkg::reg_addr_t wb_dest,
    input  exec_pkg::word_t     wb_data,
    input  logic                host_wr_valid,
    input  exec_pkg::reg_addr_t host_wr_addr,
    input  exec_pkg::word_t     host_wr_data,
    input  exec_pkg::reg_addr_t host_rd_addr,
    output exec_pkg::word_t     host_rd_data
);

    exec_pkg::word_t regs [exec_pkg::NUM_REGS];

    // The writeback is assigned last, so it wins a collision on one register
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < exec_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (host_wr_valid) begin
                regs[host_wr_addr] <= host_wr_data;
            end
            if (wb_valid) begin
                regs[wb_dest] <= wb_data;
            end
        end
    end

    // Reads return the contents from before this cycle's writes
    assign rd_data_a    = regs[rd_addr_a];
    assign rd_data_b    = regs[rd_addr_b];
    assign host_rd_data = regs[host_rd_addr];

endmodule

// File: hw/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
    input  logic                clock,
    input  logic                rst_n,
    issue_if.sink               issue,
    output logic                result_valid,
    output exec_pkg::word_t     result_data,
    output exec_pkg::reg_addr_t result_dest,
    output logic                wb_valid,
    output exec_pkg::reg_addr_t wb_dest,
    output exec_pkg::word_t     wb_data
);

    exec_pkg::opcode_e   op_in;
    exec_pkg::opcode_e   op_dly;
    exec_pkg::reg_addr_t dest_dly;
    exec_pkg::word_t     alu_data;
    logic                alu_flag;

    // An idle cycle travels down the delay line as a NOP
    assign op_in = issue.valid ? issue.opcode : exec_pkg::NOP;

    pipe_delay #(
        .T     (exec_pkg::opcode_e),
        .DEPTH (exec_pkg::ALU_DEPTH)
    ) u_op_delay (
        .clock (clock),
        .rst_n (rst_n),
        .din   (op_in),
        .dout  (op_dly)
    );

    pipe_delay #(
        .T     (exec_pkg::reg_addr_t),
        .DEPTH (exec_pkg::ALU_DEPTH)
    ) u_dest_delay (
        .clock (clock),
        .rst_n (rst_n),
        .din   (issue.dest),
        .dout  (dest_dly)
    );

    int_alu u_alu (
        .clock    (clock),
        .rst_n    (rst_n),
        .issue    (issue),
        .alu_data (alu_data),
        .alu_flag (alu_flag)
    );

    // The delayed opcode lines up with the ALU output and decides what gets written
    always_comb begin
        wb_valid = 1'b0;
        wb_data  = '0;
        wb_dest  = dest_dly;
        case (op_dly)
            exec_pkg::ADD, exec_pkg::SUB, exec_pkg::MUL,
            exec_pkg::LAND, exec_pkg::LOR, exec_pkg::LXOR, exec_pkg::LNOT,
            exec_pkg::SATP, exec_pkg::SATN, exec_pkg::ABS,
            exec_pkg::POPCNT, exec_pkg::LDC: begin
                wb_valid = 1'b1;
                wb_data  = alu_data;
            end
            exec_pkg::BGT, exec_pkg::BLE, exec_pkg::BEQ, exec_pkg::BNE: begin
                wb_valid = 1'b1;
                wb_data  = alu_flag ? '1 : '0;
            end
            default: begin
                wb_valid = 1'b0;
                wb_data  = '0;
            end
        endcase
    end

    // The register file takes the writeback at the same edge that loads these
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
            result_data  <= '0;
            result_dest  <= '0;
        end else begin
            result_valid <= wb_valid;
            result_data  <= wb_data;
            result_dest  <= wb_dest;
        end
    end

endmodule

// File: hw/int_alu.sv
`timescale 1ns/1ps

module int_alu (
    input  logic            clock,
    input  logic            rst_n,
    issue_if.sink           issue,
    output exec_pkg::word_t alu_data,
    output logic            alu_flag
);

    // Stage 1, captured operands
    exec_pkg::opcode_e s1_op;
    exec_pkg::word_t   s1_a;
    exec_pkg::word_t   s1_b;
    exec_pkg::word_t   s1_imm;

    // Stage 2, single-cycle results and the multiplier partial products
    exec_pkg::opcode_e s2_op;
    exec_pkg::word_t   s2_res;
    logic              s2_flag;
    logic [31:0]       s2_pp_ll;
    logic [31:0]       s2_pp_lh;
    logic [31:0]       s2_pp_hl;
    logic [31:0]       s2_pp_hh;

    // Stage 3, cross terms folded together
    exec_pkg::opcode_e s3_op;
    exec_pkg::word_t   s3_res;
    logic              s3_flag;
    logic [31:0]       s3_pp_ll;
    logic [31:0]       s3_pp_hh;
    logic [32:0]       s3_pp_mid;

    exec_pkg::word_t   res_c;
    logic              flag_c;
    logic              a_lt_b;
    logic              a_gt_b;
    logic [63:0]       mul_full;

    // The opcode follows the data down the stages and picks the stage 4 result
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            s1_op <= exec_pkg::NOP;
            s2_op <= exec_pkg::NOP;
            s3_op <= exec_pkg::NOP;
        end else begin
            s1_op <= issue.opcode;
            s2_op <= s1_op;
            s3_op <= s2_op;
        end
    end

    always_ff @(posedge clock) begin
        s1_a   <= issue.operand_a;
        s1_b   <= issue.operand_b;
        s1_imm <= issue.immediate;
    end

    assign a_lt_b = $signed(s1_a) < $signed(s1_b);
    assign a_gt_b = $signed(s1_a) > $signed(s1_b);

    always_comb begin
        logic [5:0] ones;
        ones = '0;
        for (int i = 0; i < exec_pkg::DATA_WIDTH; i++) begin
            ones = ones + 6'(s1_a[i]);
        end

        res_c  = '0;
        flag_c = 1'b0;
        case (s1_op)
            exec_pkg::ADD:    res_c = s1_a + s1_b;
            exec_pkg::SUB:    res_c = s1_a - s1_b;
            exec_pkg::LAND:   res_c = s1_a & s1_b;
            exec_pkg::LOR:    res_c = s1_a | s1_b;
            exec_pkg::LXOR:   res_c = s1_a ^ s1_b;
            exec_pkg::LNOT:   res_c = ~s1_a;
            exec_pkg::SATP:   res_c = a_lt_b ? s1_a : s1_b;
            exec_pkg::SATN:   res_c = a_lt_b ? s1_b : s1_a;
            // Negating 32'h8000_0000 wraps back onto itself
            exec_pkg::ABS:    res_c = s1_a[31] ? (32'd0 - s1_a) : s1_a;
            exec_pkg::POPCNT: res_c = exec_pkg::word_t'(ones);
            exec_pkg::LDC:    res_c = s1_imm;
            exec_pkg::BGT:    flag_c = a_gt_b;
            exec_pkg::BLE:    flag_c = !a_gt_b;
            exec_pkg::BEQ:    flag_c = (s1_a == s1_b);
            exec_pkg::BNE:    flag_c = (s1_a != s1_b);
            default: begin
                res_c  = '0;
                flag_c = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        s2_res   <= res_c;
        s2_flag  <= flag_c;
        s2_pp_ll <= s1_a[15:0] * s1_b[15:0];
        s2_pp_lh <= s1_a[15:0] * s1_b[31:16];
        s2_pp_hl <= s1_a[31:16] * s1_b[15:0];
        s2_pp_hh <= s1_a[31:16] * s1_b[31:16];
    end

    always_ff @(posedge clock) begin
        s3_res    <= s2_res;
        s3_flag   <= s2_flag;
        s3_pp_ll  <= s2_pp_ll;
        s3_pp_hh  <= s2_pp_hh;
        s3_pp_mid <= {1'b0, s2_pp_lh} + {1'b0, s2_pp_hl};
    end

    // The low word of the unsigned product equals the low word of the signed one
    assign mul_full = {s3_pp_hh, s3_pp_ll} + ({31'd0, s3_pp_mid} << 16);

    always_ff @(posedge clock) begin
        alu_data <= (s3_op == exec_pkg::MUL) ? mul_full[31:0] : s3_res;
        alu_flag <= s3_flag;
    end

endmodule

// File: hw/pipe_delay.sv
`timescale 1ns/1ps

module pipe_delay #(
    parameter type T     = logic,
    parameter int  DEPTH = 1
) (
    input  logic clock,
    input  logic rst_n,
    input  T     din,
    output T     dout
);

    T stages [DEPTH];

    // Plain shift chain, stage 0 takes the input
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                stages[i] <= T'(0);
            end
        end else begin
            stages[0] <= din;
            for (int i = 1; i < DEPTH; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign dout = stages[DEPTH-1];

endmodule

// File: hw/issue_if.sv
`timescale 1ns/1ps

// One issued operation, taken on every rising edge where valid is high
interface issue_if;

    logic                valid;
    exec_pkg::opcode_e   opcode;
    exec_pkg::word_t     operand_a;
    exec_pkg::word_t     operand_b;
    exec_pkg::word_t     immediate;
    exec_pkg::reg_addr_t dest;

    // Driven by the top level from the issue ports and the register file
    modport source (
        output valid, opcode, operand_a, operand_b, immediate, dest
    );

    // Seen by the exec stage and the ALU below it
    modport sink (
        input valid, opcode, operand_a, operand_b, immediate, dest
    );

endinterface

// File: hw/exec_pkg.sv
package exec_pkg;

    // Datapath geometry
    localparam int DATA_WIDTH     = 32;
    localparam int REG_ADDR_WIDTH = 4;
    localparam int NUM_REGS       = 1 << REG_ADDR_WIDTH;
    localparam int OPCODE_WIDTH   = 5;

    // Register stages inside the ALU, operand capture included
    localparam int ALU_DEPTH = 4;

    // Issue to result_valid, the ALU stages plus the exec output register
    localparam int EXEC_LATENCY = ALU_DEPTH + 1;

    typedef logic [DATA_WIDTH-1:0]     word_t;
    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

    // Codes that are not listed here are legal on the bus and produce no result
    typedef enum logic [OPCODE_WIDTH-1:0] {
        // No result
        NOP    = 5'd0,
        // Wrapping sum and difference
        ADD    = 5'd1,
        SUB    = 5'd2,
        // Low half of the signed product
        MUL    = 5'd3,
        // Bitwise operations, LNOT only uses operand a
        LAND   = 5'd4,
        LOR    = 5'd5,
        LXOR   = 5'd6,
        LNOT   = 5'd7,
        // Signed minimum and maximum of a and b
        SATP   = 5'd8,
        SATN   = 5'd9,
        // Absolute value, the most negative number maps onto itself
        ABS    = 5'd10,
        // Number of set bits in a
        POPCNT = 5'd11,
        // Load the immediate
        LDC    = 5'd12,
        // Signed compares, the exec stage expands the outcome to a full word
        BGT    = 5'd13,
        BLE    = 5'd14,
        BEQ    = 5'd15,
        BNE    = 5'd16
    } opcode_e;

endpackage
